// ==== common/stream_config.svh ====
`ifndef STREAM_CONFIG_SVH
`define STREAM_CONFIG_SVH

// FIFO depth as a power of two, shared by the sample and event FIFOs
`define STREAM_DEPTH_LOG2 3

// Zero entries sitting in the sample FIFO right after reset
`define STREAM_PREFILL 4

// Sample data word width
`define STREAM_DATA_W 16

// Cycle counter and event timestamp width
`define STREAM_TS_W 16

`endif

// ==== common/stream_pkg.sv ====
`include "stream_config.svh"

package stream_pkg;

	// One sample record as pushed by the producer
	typedef struct packed {
		logic [`STREAM_DATA_W-1:0] data; // Sample word
		logic [3:0]                chan; // Channel tag
	} sample_t;

	// What kind of fault an event reports
	typedef enum logic [1:0] {
		fault_none     = 2'd0, // Idle value on the monitor output
		fault_overrun  = 2'd1,
		fault_underrun = 2'd2
	} fault_kind_e;

	// Timestamped fault record, stored in the event FIFO
	typedef struct packed {
		fault_kind_e             kind;
		logic [`STREAM_TS_W-1:0] ts;   // Cycle count when logged
	} event_t;

endpackage

// ==== fifo/stream_fifo.sv ====
module stream_fifo #(
	parameter type T          = logic [7:0], // Payload record
	parameter int  DEPTH_LOG2 = 3,
	parameter int  PREFILL    = 0            // Zero entries present after reset
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_write,
	input  T     i_item,
	input  logic i_read,
	input  logic i_clear,
	output T     o_item,
	output logic o_valid,
	output logic o_empty,
	output logic o_full,
	output logic o_overrun,
	output logic o_underrun
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	// Reset values of the pointer and occupancy for the prefilled case
	localparam logic [DEPTH_LOG2-1:0] PREFILL_PTR = DEPTH_LOG2'(PREFILL % DEPTH);
	localparam logic [DEPTH_LOG2:0]   PREFILL_CNT = (DEPTH_LOG2 + 1)'(PREFILL);
	localparam logic [DEPTH_LOG2:0]   FULL_CNT    = (DEPTH_LOG2 + 1)'(DEPTH);

	T mem [DEPTH]; // Storage array

	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0]   count;  // One extra bit so full and empty differ
	logic                  empty;
	logic                  full;
	logic                  wr_accept;
	logic                  rd_accept;
	logic                  wr_drop;
	logic                  rd_fail;

	assign empty = (count == '0);
	assign full  = (count == FULL_CNT);

	// Read only succeeds with data present, a write in the same cycle does not help
	assign rd_accept = i_read & ~empty;
	assign rd_fail   = i_read & empty;

	// Write goes through when there is room, or when full and a read frees a slot
	assign wr_accept = i_write & (~full | i_read);
	assign wr_drop   = i_write & full & ~i_read;

	// Occupancy
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			count <= PREFILL_CNT;
		end else begin
			case ({wr_accept, rd_accept})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Idle, or push and pop together
			endcase
		end
	end

	// Pointers wrap naturally at DEPTH
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_ptr <= PREFILL_PTR; // Prefilled slots sit below the write pointer
			rd_ptr <= '0;
		end else begin
			if (wr_accept)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_accept)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage, only the prefilled slots are touched by reset
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				if (i < PREFILL)
					mem[i] <= T'('0);
			end
		end else if (wr_accept) begin
			mem[wr_ptr] <= i_item; // When full this overwrites the slot being popped
		end
	end

	// Read data is captured only on an accepted pop
	// Nonblocking read of mem gives the old head even on write-through
	always_ff @(posedge i_clk) begin
		if (rd_accept)
			o_item <= mem[rd_ptr];
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n)
			o_valid <= 1'b0;
		else
			o_valid <= rd_accept; // One-cycle pulse with the data
	end

	// Sticky fault flags
	// A new fault in the clear cycle wins so the event is not lost
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_overrun  <= 1'b0;
			o_underrun <= 1'b0;
		end else begin
			o_overrun  <= wr_drop | (o_overrun & ~i_clear);
			o_underrun <= rd_fail | (o_underrun & ~i_clear);
		end
	end

	assign o_empty = empty;
	assign o_full  = full;

endmodule

// ==== logic/fault_monitor.sv ====
`include "stream_config.svh"

module fault_monitor (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_overrun,  // Sticky flag from the sample FIFO
	input  logic                i_underrun, // Sticky flag from the sample FIFO
	output logic                o_push,     // Write strobe into the event FIFO
	output stream_pkg::event_t  o_event
);

	logic [`STREAM_TS_W-1:0] cycle_cnt; // Free-running timestamp source
	logic                    ovr_q;     // Flag values one cycle back
	logic                    udr_q;
	logic                    ovr_rise;
	logic                    udr_rise;
	logic                    pend_udr;  // Underrun waiting behind an overrun
	logic                    push_next;
	stream_pkg::fault_kind_e kind_next;

	// Only a 0 to 1 step counts, a clear just drops the flags
	assign ovr_rise = i_overrun & ~ovr_q;
	assign udr_rise = i_underrun & ~udr_q;

	// Pick at most one event per cycle
	// Pending underrun goes first; a fresh rise cannot meet it since a flag
	// needs a clear cycle before it can rise again
	always_comb begin
		push_next = 1'b1;
		kind_next = stream_pkg::fault_none;
		if (pend_udr)
			kind_next = stream_pkg::fault_underrun;
		else if (ovr_rise)
			kind_next = stream_pkg::fault_overrun; // Overrun first on a double fault
		else if (udr_rise)
			kind_next = stream_pkg::fault_underrun;
		else
			push_next = 1'b0;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n)
			cycle_cnt <= '0;
		else
			cycle_cnt <= cycle_cnt + 1'b1; // Wraps silently
	end

	// Edge detect history
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			ovr_q <= 1'b0;
			udr_q <= 1'b0;
		end else begin
			ovr_q <= i_overrun;
			udr_q <= i_underrun;
		end
	end

	// Second half of a simultaneous rise, held for one cycle
	always_ff @(posedge i_clk) begin
		if (!i_rst_n)
			pend_udr <= 1'b0;
		else
			pend_udr <= ovr_rise & udr_rise & ~pend_udr;
	end

	// Registered push, so the FIFO sees it one edge after detection
	always_ff @(posedge i_clk) begin
		if (!i_rst_n)
			o_push <= 1'b0;
		else
			o_push <= push_next;
	end

	// Record is stamped when it is issued
	// The delayed underrun thus carries a later stamp than its overrun
	always_ff @(posedge i_clk) begin
		o_event.kind <= kind_next;
		o_event.ts   <= cycle_cnt;
	end

endmodule

// ==== logic/stream_buffer_top.sv ====
`include "stream_config.svh"

module stream_buffer_top (
	input  logic                i_clk,
	input  logic                i_rst_n,
	// Producer side
	input  logic                i_sample_write,
	input  stream_pkg::sample_t i_sample,
	// Consumer side
	input  logic                i_sample_read,
	output stream_pkg::sample_t o_sample,
	output logic                o_sample_valid,
	output logic                o_empty,
	output logic                o_full,
	output logic                o_overrun,
	output logic                o_underrun,
	// Host side, fault log
	input  logic                i_clear_faults,
	input  logic                i_evt_read,
	output stream_pkg::event_t  o_evt,
	output logic                o_evt_valid,
	output logic                o_evt_empty,
	output logic                o_evt_lost
);

	logic               evt_push; // Monitor to event FIFO
	stream_pkg::event_t evt_rec;

	// Rate-matching buffer, starts as a delay line of zeros
	stream_fifo #(
		.T          (stream_pkg::sample_t),
		.DEPTH_LOG2 (`STREAM_DEPTH_LOG2),
		.PREFILL    (`STREAM_PREFILL)
	) u_sample_fifo (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_write    (i_sample_write),
		.i_item     (i_sample),
		.i_read     (i_sample_read),
		.i_clear    (i_clear_faults),
		.o_item     (o_sample),
		.o_valid    (o_sample_valid),
		.o_empty    (o_empty),
		.o_full     (o_full),
		.o_overrun  (o_overrun),
		.o_underrun (o_underrun)
	);

	// Turns flag rises into timestamped records
	fault_monitor u_fault_monitor (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_overrun  (o_overrun),
		.i_underrun (o_underrun),
		.o_push     (evt_push),
		.o_event    (evt_rec)
	);

	// Fault log, drained by the host
	// Its overrun means events were dropped, underrun is of no interest
	stream_fifo #(
		.T          (stream_pkg::event_t),
		.DEPTH_LOG2 (`STREAM_DEPTH_LOG2),
		.PREFILL    (0)
	) u_event_fifo (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_write    (evt_push),
		.i_item     (evt_rec),
		.i_read     (i_evt_read),
		.i_clear    (i_clear_faults),
		.o_item     (o_evt),
		.o_valid    (o_evt_valid),
		.o_empty    (o_evt_empty),
		.o_full     (),
		.o_overrun  (o_evt_lost),
		.o_underrun ()
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator and run; the exit status carries the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module stream_buffer_tb \
	-f sim.f \
	-o stream_buffer_sim \
	&& ./obj_dir/stream_buffer_sim \
	|| { echo "Simulation build or run failed"; exit 1; }

exit 0

// ==== sim.f ====
+incdir+common
common/stream_pkg.sv
fifo/stream_fifo.sv
logic/fault_monitor.sv
logic/stream_buffer_top.sv
verification/stream_buffer_asserts.sv
verification/stream_buffer_tb.sv

// ==== verification/stream_buffer_asserts.sv ====
module stream_buffer_asserts (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_sample_write,
	input logic i_sample_read,
	input logic i_clear,
	input logic i_sample_valid,
	input logic i_empty,
	input logic i_full,
	input logic i_overrun,
	input logic i_underrun,
	input logic i_evt_empty
);
	timeunit 1ns;
	timeprecision 100ps;

	logic drop; // Write lost on a full FIFO
	logic fail; // Read of an empty FIFO

	assign drop = i_sample_write & i_full & ~i_sample_read;
	assign fail = i_sample_read & i_empty;

	// Accepted pop gives valid on the next cycle, and only then
	a_valid_after_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_sample_read && !i_empty |=> i_sample_valid) else $error("Pop without valid pulse");
	a_valid_only_after_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_sample_valid |-> $past(i_sample_read && !i_empty)) else $error("Stray valid pulse");

	// Levels only move on an accepted strobe
	a_empty_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_empty && !i_sample_write |=> i_empty) else $error("Empty dropped without a write");
	a_full_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_full && !i_sample_read |=> i_full) else $error("Full dropped without a read");

	// Overrun rules
	a_overrun_set: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		drop |=> i_overrun) else $error("Dropped write did not set overrun");
	a_overrun_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_overrun && !i_clear |=> i_overrun) else $error("Overrun fell without clear");
	a_overrun_cause: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_overrun && !drop |=> !i_overrun) else $error("Overrun rose without a drop");
	a_overrun_clear: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_clear && !drop |=> !i_overrun) else $error("Clear left overrun set");
	a_write_through: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_sample_write && i_sample_read && i_full |=> i_full)
		else $error("Write with read on full FIFO changed level");

	// Underrun rules, a failed read never shows valid
	a_underrun_set: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		fail |=> i_underrun && !i_sample_valid) else $error("Empty read not flagged");
	a_underrun_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_underrun && !i_clear |=> i_underrun) else $error("Underrun fell without clear");
	a_underrun_clear: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_clear && !fail |=> !i_underrun) else $error("Clear left underrun set");

	// Flag rise reaches the event FIFO two cycles later
	a_overrun_logged: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$past(i_overrun, 2) && !$past(i_overrun, 3) |-> !i_evt_empty)
		else $error("Overrun rise not logged in time");
	a_underrun_logged: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$past(i_underrun, 2) && !$past(i_underrun, 3) |-> !i_evt_empty)
		else $error("Underrun rise not logged in time");

endmodule

// ==== verification/stream_buffer_tb.sv ====
`include "stream_config.svh"

module stream_buffer_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH    = 1 << `STREAM_DEPTH_LOG2;
	localparam int SAMPLE_W = $bits(stream_pkg::sample_t);

	logic                i_clk = 1'b0;
	logic                i_rst_n;
	logic                i_sample_write;
	stream_pkg::sample_t i_sample;
	logic                i_sample_read;
	logic                i_clear_faults;
	logic                i_evt_read;
	stream_pkg::sample_t o_sample;
	logic                o_sample_valid;
	logic                o_empty;
	logic                o_full;
	logic                o_overrun;
	logic                o_underrun;
	stream_pkg::event_t  o_evt;
	logic                o_evt_valid;
	logic                o_evt_empty;
	logic                o_evt_lost;

	logic [31:0]             lfsr_state = 32'h8aa7_e8a0;
	stream_pkg::sample_t     ref_q[$];   // Samples expected to come out, in order
	stream_pkg::event_t      evt_q[$];   // Events expected from the log
	stream_pkg::sample_t     exp_item;
	logic                    exp_valid = 1'b0;
	logic                    model_live = 1'b0; // Model out of reset
	logic                    m_ovr;
	logic                    m_udr;
	logic [`STREAM_TS_W-1:0] m_cycle;    // Mirrors the free-running counter

	stream_buffer_top dut (.*);

	bind stream_buffer_top stream_buffer_asserts u_asserts (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_sample_write (i_sample_write),
		.i_sample_read  (i_sample_read),
		.i_clear        (i_clear_faults),
		.i_sample_valid (o_sample_valid),
		.i_empty        (o_empty),
		.i_full         (o_full),
		.i_overrun      (o_overrun),
		.i_underrun     (o_underrun),
		.i_evt_empty    (o_evt_empty)
	);

	always #2 i_clk = ~i_clk; // 4 ns period

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %0t ns %s expected 0x%0h got 0x%0h",
				$time, name, exp, got));
	endtask

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr_state[0]}; // One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
		return bits;
	endfunction

	task automatic drive(input logic wr, input logic rd, input logic clr);
		@(negedge i_clk);
		i_sample_write = wr;
		i_sample_read  = rd;
		i_clear_faults = clr;
		i_sample       = SAMPLE_W'(rand_bits(SAMPLE_W));
	endtask

	// Pop until the DUT reports empty
	task automatic drain_samples();
		int n;
		n = 0;
		drive(1'b0, 1'b0, 1'b0);
		while (!o_empty && n < 64) begin
			i_sample_read = 1'b1;
			@(negedge i_clk);
			n++;
		end
		i_sample_read = 1'b0;
		if (!o_empty)
			stop_with_failure("Timeout: sample FIFO never ran empty while draining");
	endtask

	// No pop in flight and nothing left to come out of the log
	function automatic logic events_settled();
		return evt_q.size() == 0 && o_evt_empty && !o_evt_valid;
	endfunction

	task automatic wait_events_drained();
		int n;
		n = 0;
		drive(1'b0, 1'b0, 1'b0);
		while (!events_settled() && n < 32) begin
			@(negedge i_clk);
			n++;
		end
		if (!events_settled())
			stop_with_failure("Timeout: an expected fault event never left the event FIFO");
	endtask

	// Reference model, updated on the same edge as the DUT
	always @(posedge i_clk) begin : ref_model
		logic rd_ok;
		logic wr_ok;
		logic ovr_new;
		logic udr_new;
		stream_pkg::event_t ev;
		if (!i_rst_n) begin
			ref_q.delete();
			evt_q.delete();
			repeat (`STREAM_PREFILL) ref_q.push_back('0); // Zero prefill
			m_cycle    = '0;
			m_ovr      = 1'b0;
			m_udr      = 1'b0;
			exp_valid  = 1'b0;
			model_live = 1'b0;
		end else begin
			model_live = 1'b1;
			m_cycle    = m_cycle + 1'b1;
			rd_ok   = i_sample_read && ref_q.size() != 0;
			wr_ok   = i_sample_write && (ref_q.size() != DEPTH || i_sample_read);
			ovr_new = (i_sample_write && ref_q.size() == DEPTH && !i_sample_read)
				|| (m_ovr && !i_clear_faults);
			udr_new = (i_sample_read && ref_q.size() == 0) || (m_udr && !i_clear_faults);
			exp_valid = rd_ok;
			if (rd_ok)
				exp_item = ref_q.pop_front();
			if (wr_ok)
				ref_q.push_back(i_sample);
			// Stamp is the count on the edge that pushes, one later for a queued underrun
			if (ovr_new && !m_ovr) begin
				ev.kind = stream_pkg::fault_overrun;
				ev.ts   = m_cycle;
				evt_q.push_back(ev);
			end
			if (udr_new && !m_udr) begin
				ev.kind = stream_pkg::fault_underrun;
				ev.ts   = (ovr_new && !m_ovr) ? m_cycle + 1'b1 : m_cycle;
				evt_q.push_back(ev);
			end
			m_ovr = ovr_new;
			m_udr = udr_new;
		end
	end

	// Outputs compared mid-cycle
	always @(negedge i_clk) begin
		stream_pkg::event_t exp_evt;
		if (model_live) begin
			check_value("o_sample_valid", 32'(o_sample_valid), 32'(exp_valid));
			if (exp_valid)
				check_value("o_sample", 32'(o_sample), 32'(exp_item));
			check_value("o_empty", 32'(o_empty), 32'(ref_q.size() == 0));
			check_value("o_full", 32'(o_full), 32'(ref_q.size() == DEPTH));
			check_value("o_overrun", 32'(o_overrun), 32'(m_ovr));
			check_value("o_underrun", 32'(o_underrun), 32'(m_udr));
			// Host pops each event the cycle after it lands, the log never fills
			check_value("o_evt_lost", 32'(o_evt_lost), 32'(1'b0));
			if (o_evt_valid) begin
				if (evt_q.size() == 0) begin
					stop_with_failure("Event FIFO returned an event when no fault was logged");
				end else begin
					exp_evt = evt_q.pop_front();
					check_value("o_evt", 32'(o_evt), 32'(exp_evt));
				end
			end
		end
	end

	// Host drains the log whenever it holds something
	initial begin
		i_evt_read = 1'b0;
		forever begin
			@(negedge i_clk);
			i_evt_read = model_live && !o_evt_empty;
		end
	end

	initial begin
		logic [31:0] r;
		logic        wr;
		logic        rd;
		i_rst_n        = 1'b0;
		i_sample_write = 1'b0;
		i_sample       = '0;
		i_sample_read  = 1'b0;
		i_clear_faults = 1'b0;
		repeat (5) @(posedge i_clk);
		@(negedge i_clk);
		i_rst_n = 1'b1;

		repeat (`STREAM_PREFILL) drive(1'b0, 1'b1, 1'b0); // Prefill zeros come out first
		drive(1'b1, 1'b1, 1'b0);                          // Empty: write kept, read fails
		repeat (DEPTH - 1) drive(1'b1, 1'b0, 1'b0);       // Up to full
		drive(1'b1, 1'b0, 1'b0);                          // Dropped, overrun
		drive(1'b1, 1'b1, 1'b0);                          // Write-through on full
		wait_events_drained();
		drive(1'b0, 1'b0, 1'b1);                          // One clear for both flags

		// Write-heavy half then read-heavy half, with rare clears
		for (int i = 0; i < 400; i++) begin
			r  = rand_bits(8);
			wr = (i < 200) ? (r[0] | r[1]) : (r[0] & r[1]);
			rd = (i < 200) ? (r[2] & r[3]) : (r[2] | r[3]);
			drive(wr, rd, r[7:4] == 4'd0);
		end

		drain_samples();
		wait_events_drained();
		$display("RESULT: PASS");
		$finish;
	end

endmodule
